// ==== src/sprite_fetch_params.svh ====
`ifndef SPRITE_FETCH_PARAMS_SVH
`define SPRITE_FETCH_PARAMS_SVH

// ========================================
// Sprite fetch path widths
// ========================================

// Sprite number selects one of 32 sprite regions in the cache
`define SPR_NUM_W 5

// Byte address from the sprite engine
`define ADDR_W 32

// One cache line holds four 32-bit words
`define LINE_W 128

// Byte offset of an address inside its line
`define LINE_OFS_W 4

// Address bits above the offset that pick one of 16 lines per sprite
`define SET_LO_W 4

// The tag keeps every address bit above the line offset
`define TAG_W (`ADDR_W - `LINE_OFS_W)
`define SET_W (`SPR_NUM_W + `SET_LO_W)

`endif

// ==== src/sprite_fetch_pkg.sv ====
`default_nettype none

`include "sprite_fetch_params.svh"

package sprite_fetch_pkg;

	// ========================================
	// Vector types
	// ========================================

	// Sprite number as presented by the sprite engine
	typedef logic [`SPR_NUM_W-1:0] spr_num_t;

	// Byte address of a sprite line
	typedef logic [`ADDR_W-1:0] addr_t;

	// Cache line with word 0 in the low 32 bits
	typedef logic [`LINE_W-1:0] line_t;

	// Line tag, the address without its byte offset
	typedef logic [`TAG_W-1:0] tag_t;

	// Set index is the sprite number on top of the low line-address bits
	typedef logic [`SET_W-1:0] set_idx_t;

	// Miss unit states
	// Idle answers hits straight away, mem_wait holds the read, drain empties the queue
	typedef enum logic [1:0] {
		idle,
		mem_wait,
		drain
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== src/sprite_req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_fetch_params.svh"

module sprite_req_stage (
	input  logic                       rclk,
	input  logic                       rst,
	input  logic                       req,
	input  sprite_fetch_pkg::spr_num_t req_spr,
	input  sprite_fetch_pkg::addr_t    req_adr,
	input  logic                       busy,
	output logic                       lk_vld,
	output sprite_fetch_pkg::set_idx_t lk_set,
	output sprite_fetch_pkg::tag_t     lk_tag,
	output logic                       pl_vld,
	output sprite_fetch_pkg::set_idx_t pl_set,
	output sprite_fetch_pkg::tag_t     pl_tag
);

	// Middle tap of the delay line toward the miss unit
	logic                       dly_vld;
	sprite_fetch_pkg::set_idx_t dly_set;
	sprite_fetch_pkg::tag_t     dly_tag;
	logic                       accept;

	// A strobe that arrives while the miss unit is busy is dropped
	assign accept = req && !busy;

	// ========================================
	// Valid bits of the request pipeline
	// ========================================

	always_ff @(posedge rclk) begin
		if (rst) begin
			lk_vld  <= 1'b0;
			dly_vld <= 1'b0;
			pl_vld  <= 1'b0;
		end else begin
			lk_vld  <= accept;
			// Two stages here match the address and array registers in the cache
			dly_vld <= lk_vld;
			pl_vld  <= dly_vld;
		end
	end

	// ========================================
	// Set index and tag
	// ========================================

	always_ff @(posedge rclk) begin
		if (accept) begin
			// Each sprite owns 16 consecutive sets picked by address bits 7:4
			lk_set <= {req_spr, req_adr[`LINE_OFS_W+`SET_LO_W-1:`LINE_OFS_W]};
			lk_tag <= req_adr[`ADDR_W-1:`LINE_OFS_W];
		end
		dly_set <= lk_set;
		dly_tag <= lk_tag;
		pl_set  <= dly_set;
		pl_tag  <= dly_tag;
	end

endmodule

`default_nettype wire

// ==== src/sprite_read_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_fetch_params.svh"

module sprite_read_cache (
	input  logic                       rclk,
	input  logic                       rst,
	input  logic                       lk_vld,
	input  sprite_fetch_pkg::set_idx_t lk_set,
	input  sprite_fetch_pkg::tag_t     lk_tag,
	input  logic                       fill_wr,
	input  sprite_fetch_pkg::set_idx_t fill_set,
	input  sprite_fetch_pkg::tag_t     fill_tag,
	input  sprite_fetch_pkg::line_t    fill_line,
	input  logic                       inv,
	input  sprite_fetch_pkg::spr_num_t inv_spr,
	input  sprite_fetch_pkg::addr_t    inv_adr,
	output sprite_fetch_pkg::line_t    cache_line,
	output logic                       cache_hit
);

	localparam int n_sets = 1 << `SET_W;

	// Line and tag storage maps onto block RAM
	sprite_fetch_pkg::line_t lines [0:n_sets-1];
	sprite_fetch_pkg::tag_t  tags  [0:n_sets-1];

	// One valid bit per set, kept in flops so reset can clear all of them
	logic [n_sets-1:0] vbits;

	// Lookup address register
	sprite_fetch_pkg::set_idx_t rd_set;
	sprite_fetch_pkg::tag_t     rd_tag;

	// Array outputs and the tag they are compared against
	sprite_fetch_pkg::tag_t tag_o;
	sprite_fetch_pkg::tag_t cmp_tag;
	logic                   vbit_o;

	sprite_fetch_pkg::set_idx_t inv_set;

	// Invalidates name a set the same way a request does
	assign inv_set = {inv_spr, inv_adr[`LINE_OFS_W+`SET_LO_W-1:`LINE_OFS_W]};

	// ========================================
	// Lookup
	// ========================================

	// The address register holds its last lookup between strobes
	always_ff @(posedge rclk) begin
		if (lk_vld) begin
			rd_set <= lk_set;
			rd_tag <= lk_tag;
		end
	end

	// Registered array read
	always_ff @(posedge rclk) begin
		cache_line <= lines[rd_set];
		tag_o      <= tags[rd_set];
		vbit_o     <= vbits[rd_set];
		// Tag follows the read by one more cycle so back-to-back lookups compare correctly
		cmp_tag    <= rd_tag;
	end

	assign cache_hit = vbit_o && (tag_o == cmp_tag);

	// ========================================
	// Refill and invalidate
	// ========================================

	always_ff @(posedge rclk) begin
		if (fill_wr) begin
			lines[fill_set] <= fill_line;
			tags[fill_set]  <= fill_tag;
		end
	end

	always_ff @(posedge rclk) begin
		if (rst) begin
			vbits <= '0;
		end else begin
			if (inv) begin
				vbits[inv_set] <= 1'b0;
			end
			// Written last so a refill to the same set beats the invalidate
			if (fill_wr) begin
				vbits[fill_set] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/sprite_miss_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_fetch_params.svh"

module sprite_miss_fetch (
	input  logic                       rclk,
	input  logic                       rst,
	input  logic                       pl_vld,
	input  sprite_fetch_pkg::set_idx_t pl_set,
	input  sprite_fetch_pkg::tag_t     pl_tag,
	input  logic                       cache_hit,
	input  sprite_fetch_pkg::line_t    cache_line,
	input  logic                       mem_ack,
	input  sprite_fetch_pkg::line_t    mem_dat,
	output logic                       busy,
	output logic                       fill_wr,
	output sprite_fetch_pkg::set_idx_t fill_set,
	output sprite_fetch_pkg::tag_t     fill_tag,
	output sprite_fetch_pkg::line_t    fill_line,
	output logic                       mem_rd,
	output sprite_fetch_pkg::addr_t    mem_adr,
	output logic                       rsp_vld,
	output sprite_fetch_pkg::line_t    rsp_line,
	output logic                       rsp_hit
);

	// Queue slots are numbered 0 to q_last and wrap
	localparam logic [1:0] q_last = 2'd2;

	sprite_fetch_pkg::fetch_state_e state;

	// In-order queue of the miss and the lookups behind it
	sprite_fetch_pkg::set_idx_t q_set  [0:q_last];
	sprite_fetch_pkg::tag_t     q_tag  [0:q_last];
	sprite_fetch_pkg::line_t    q_line [0:q_last];
	logic [q_last:0]            q_hit;
	logic [1:0]                 rd_ptr;
	logic [1:0]                 wr_ptr;
	logic [1:0]                 q_cnt;

	sprite_fetch_pkg::set_idx_t head_set;
	sprite_fetch_pkg::tag_t     head_tag;
	sprite_fetch_pkg::line_t    head_line;
	logic                       head_hit;
	logic                       q_empty;
	logic                       push;
	logic                       pop;
	logic                       idle_hit;
	logic                       fill_done;
	logic                       drain_hit;

	function automatic logic [1:0] next_ptr(input logic [1:0] p);
		return (p == q_last) ? 2'd0 : p + 2'd1;
	endfunction

	assign head_set  = q_set[rd_ptr];
	assign head_tag  = q_tag[rd_ptr];
	assign head_line = q_line[rd_ptr];
	assign head_hit  = q_hit[rd_ptr];
	assign q_empty   = (q_cnt == 2'd0);

	// ========================================
	// Stage decode
	// ========================================

	// Outside idle every arriving lookup queues behind the miss, hit or not
	assign push      = pl_vld && ((state != sprite_fetch_pkg::idle) || !cache_hit);
	assign idle_hit  = (state == sprite_fetch_pkg::idle) && pl_vld && cache_hit;
	assign fill_done = (state == sprite_fetch_pkg::mem_wait) && mem_ack;
	assign drain_hit = (state == sprite_fetch_pkg::drain) && !q_empty && head_hit;
	assign pop       = fill_done || drain_hit;

	// Raised as soon as a miss shows at this stage so at most two lookups trail it
	assign busy = (state != sprite_fetch_pkg::idle) || (pl_vld && !cache_hit);

	// The head entry is the miss for the whole read
	assign mem_rd  = (state == sprite_fetch_pkg::mem_wait);
	assign mem_adr = {head_tag, {`LINE_OFS_W{1'b0}}};

	// ========================================
	// Control
	// ========================================

	always_ff @(posedge rclk) begin
		if (rst) begin
			state   <= sprite_fetch_pkg::idle;
			rd_ptr  <= 2'd0;
			wr_ptr  <= 2'd0;
			q_cnt   <= 2'd0;
			rsp_vld <= 1'b0;
			rsp_hit <= 1'b0;
			fill_wr <= 1'b0;
		end else begin
			rsp_vld <= idle_hit || fill_done || drain_hit;
			// A refilled line reports a miss
			rsp_hit <= idle_hit || drain_hit;
			fill_wr <= fill_done;
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
			case (state)
				// In idle a push can only be a miss
				sprite_fetch_pkg::idle: if (push) state <= sprite_fetch_pkg::mem_wait;
				sprite_fetch_pkg::mem_wait: if (mem_ack) state <= sprite_fetch_pkg::drain;
				sprite_fetch_pkg::drain: begin
					if (!q_empty && !head_hit) begin
						state <= sprite_fetch_pkg::mem_wait;
					end else if (q_empty && !pl_vld) begin
						state <= sprite_fetch_pkg::idle;
					end
				end
				default: state <= sprite_fetch_pkg::idle;
			endcase
		end
	end

	// ========================================
	// Queue and response data
	// ========================================

	always_ff @(posedge rclk) begin
		// Entries that looked up the refilled set before the fill see the new line
		// Same tag turns into a hit, any other tag now needs its own refill
		if (fill_done) begin
			for (int i = 0; i <= q_last; i++) begin
				if (q_set[i] == head_set) begin
					q_hit[i]  <= (q_tag[i] == head_tag);
					q_line[i] <= mem_dat;
				end
			end
			fill_set  <= head_set;
			fill_tag  <= head_tag;
			fill_line <= mem_dat;
		end
		if (push) begin
			q_set[wr_ptr]  <= pl_set;
			q_tag[wr_ptr]  <= pl_tag;
			q_hit[wr_ptr]  <= cache_hit;
			q_line[wr_ptr] <= cache_line;
		end
		if (idle_hit) begin
			rsp_line <= cache_line;
		end else if (fill_done) begin
			rsp_line <= mem_dat;
		end else if (drain_hit) begin
			rsp_line <= head_line;
		end
	end

endmodule

`default_nettype wire

// ==== src/sprite_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_fetch_top (
	input  logic                       rclk,
	input  logic                       rst,
	input  logic                       req,
	input  sprite_fetch_pkg::spr_num_t req_spr,
	input  sprite_fetch_pkg::addr_t    req_adr,
	input  logic                       inv,
	input  sprite_fetch_pkg::spr_num_t inv_spr,
	input  sprite_fetch_pkg::addr_t    inv_adr,
	input  logic                       mem_ack,
	input  sprite_fetch_pkg::line_t    mem_dat,
	output logic                       busy,
	output logic                       rsp_vld,
	output sprite_fetch_pkg::line_t    rsp_line,
	output logic                       rsp_hit,
	output logic                       mem_rd,
	output sprite_fetch_pkg::addr_t    mem_adr
);

	// ========================================
	// Stage to stage wiring
	// ========================================

	// Lookup into the cache
	logic                       lk_vld;
	sprite_fetch_pkg::set_idx_t lk_set;
	sprite_fetch_pkg::tag_t     lk_tag;

	// Same lookup, aligned with the cache result
	logic                       pl_vld;
	sprite_fetch_pkg::set_idx_t pl_set;
	sprite_fetch_pkg::tag_t     pl_tag;

	logic                    cache_hit;
	sprite_fetch_pkg::line_t cache_line;

	// Refill write from the miss unit
	logic                       fill_wr;
	sprite_fetch_pkg::set_idx_t fill_set;
	sprite_fetch_pkg::tag_t     fill_tag;
	sprite_fetch_pkg::line_t    fill_line;

	sprite_req_stage u_req (
		.rclk    (rclk),
		.rst     (rst),
		.req     (req),
		.req_spr (req_spr),
		.req_adr (req_adr),
		.busy    (busy),
		.lk_vld  (lk_vld),
		.lk_set  (lk_set),
		.lk_tag  (lk_tag),
		.pl_vld  (pl_vld),
		.pl_set  (pl_set),
		.pl_tag  (pl_tag)
	);

	// Invalidates go to the cache without passing the request pipeline
	sprite_read_cache u_cache (
		.rclk       (rclk),
		.rst        (rst),
		.lk_vld     (lk_vld),
		.lk_set     (lk_set),
		.lk_tag     (lk_tag),
		.fill_wr    (fill_wr),
		.fill_set   (fill_set),
		.fill_tag   (fill_tag),
		.fill_line  (fill_line),
		.inv        (inv),
		.inv_spr    (inv_spr),
		.inv_adr    (inv_adr),
		.cache_line (cache_line),
		.cache_hit  (cache_hit)
	);

	sprite_miss_fetch u_miss (
		.rclk       (rclk),
		.rst        (rst),
		.pl_vld     (pl_vld),
		.pl_set     (pl_set),
		.pl_tag     (pl_tag),
		.cache_hit  (cache_hit),
		.cache_line (cache_line),
		.mem_ack    (mem_ack),
		.mem_dat    (mem_dat),
		.busy       (busy),
		.fill_wr    (fill_wr),
		.fill_set   (fill_set),
		.fill_tag   (fill_tag),
		.fill_line  (fill_line),
		.mem_rd     (mem_rd),
		.mem_adr    (mem_adr),
		.rsp_vld    (rsp_vld),
		.rsp_line   (rsp_line),
		.rsp_hit    (rsp_hit)
	);

endmodule

`default_nettype wire

// ==== testbench/sprite_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_mem_model (
	input  logic                    rclk,
	input  logic                    rst,
	input  logic                    mem_rd,
	input  sprite_fetch_pkg::addr_t mem_adr,
	output logic                    mem_ack,
	output sprite_fetch_pkg::line_t mem_dat
);

	logic [31:0] lfsr_state;
	logic        waiting;
	int          count;

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Memory contents follow from the aligned address alone
	function automatic sprite_fetch_pkg::line_t mem_line(input sprite_fetch_pkg::addr_t a);
		return {{a[23:0], a[31:24]}, a + 32'h1357_9bdf, ~a, a};
	endfunction

	// ========================================
	// Read with a random latency of 1 to 8 cycles
	// ========================================

	always @(posedge rclk) begin
		if (rst) begin
			mem_ack    <= 1'b0;
			mem_dat    <= '0;
			waiting    <= 1'b0;
			count      <= 0;
			lfsr_state <= 32'h52bc79f9;
		end else if (mem_ack) begin
			// The miss unit drops mem_rd in the cycle after the ack
			mem_ack <= 1'b0;
			waiting <= 1'b0;
		end else if (mem_rd && !waiting) begin
			// Three LFSR steps give three delay bits
			lfsr_state <= lfsr_step(lfsr_step(lfsr_step(lfsr_state)));
			count      <= int'(lfsr_step(lfsr_step(lfsr_step(lfsr_state))) & 32'h7);
			waiting    <= 1'b1;
		end else if (waiting) begin
			if (count == 0) begin
				mem_ack <= 1'b1;
				mem_dat <= mem_line({mem_adr[31:4], 4'h0});
			end else begin
				count <= count - 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/sprite_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_fetch_tb;

	localparam int wait_limit = 2000;

	logic                       rclk;
	logic                       rst;
	logic                       req;
	sprite_fetch_pkg::spr_num_t req_spr;
	sprite_fetch_pkg::addr_t    req_adr;
	logic                       inv;
	sprite_fetch_pkg::spr_num_t inv_spr;
	sprite_fetch_pkg::addr_t    inv_adr;
	logic                       mem_ack;
	sprite_fetch_pkg::line_t    mem_dat;
	logic                       busy;
	logic                       rsp_vld;
	sprite_fetch_pkg::line_t    rsp_line;
	logic                       rsp_hit;
	logic                       mem_rd;
	sprite_fetch_pkg::addr_t    mem_adr;

	// Reference tag and valid arrays, indexed like the cache
	logic [27:0] ref_tag [0:511];
	logic        ref_vld [0:511];

	// Expected responses in request order
	sprite_fetch_pkg::line_t exp_line [$];
	logic                    exp_hit  [$];
	int                      exp_cyc  [$];
	string                   exp_name [$];

	logic [31:0]             lfsr_state;
	int                      cyc;
	int                      errors;
	int                      checks;
	int                      tests;
	int                      test_err0;
	string                   test_name;
	logic                    chk_lat;
	int                      mem_reads;
	sprite_fetch_pkg::addr_t last_mem_adr;
	logic                    rd_seen;
	logic                    busy_seen;
	sprite_fetch_pkg::spr_num_t sprs [0:3];
	sprite_fetch_pkg::addr_t    adrs [0:3];

	sprite_fetch_top dut0 (
		.rclk     (rclk),
		.rst      (rst),
		.req      (req),
		.req_spr  (req_spr),
		.req_adr  (req_adr),
		.inv      (inv),
		.inv_spr  (inv_spr),
		.inv_adr  (inv_adr),
		.mem_ack  (mem_ack),
		.mem_dat  (mem_dat),
		.busy     (busy),
		.rsp_vld  (rsp_vld),
		.rsp_line (rsp_line),
		.rsp_hit  (rsp_hit),
		.mem_rd   (mem_rd),
		.mem_adr  (mem_adr)
	);

	sprite_mem_model mem0 (
		.rclk    (rclk),
		.rst     (rst),
		.mem_rd  (mem_rd),
		.mem_adr (mem_adr),
		.mem_ack (mem_ack),
		.mem_dat (mem_dat)
	);

	always #5 rclk = ~rclk;

	always @(posedge rclk) begin
		cyc <= cyc + 1;
	end

	// ========================================
	// Reference and helpers
	// ========================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Takes n fresh bits, one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Words are the address, its inverse, an offset copy and a rotation
	function automatic sprite_fetch_pkg::line_t line_of(input sprite_fetch_pkg::addr_t a);
		return {{a[23:0], a[31:24]}, a + 32'h1357_9bdf, ~a, a};
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("TIMEOUT: %s never came", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic check_line(input string name, input sprite_fetch_pkg::line_t exp,
			input sprite_fetch_pkg::line_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s line: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s hit: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s busy: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_adr(input string name, input sprite_fetch_pkg::addr_t exp,
			input sprite_fetch_pkg::addr_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s mem_adr: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("MISMATCH %s count: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// ========================================
	// Response compare and memory monitor
	// ========================================

	always @(negedge rclk) begin
		if (!rst && rsp_vld) begin
			if (exp_line.size() == 0) begin
				errors++;
				$display("ERROR: a response came with no request outstanding");
			end else begin
				check_line(exp_name[0], exp_line[0], rsp_line);
				check_hit(exp_name[0], exp_hit[0], rsp_hit);
				// Hits on a quiet pipeline come four cycles after the request
				if (exp_cyc[0] >= 0) begin
					check_count({exp_name[0], " latency"}, 4, cyc - exp_cyc[0]);
				end
				void'(exp_line.pop_front());
				void'(exp_hit.pop_front());
				void'(exp_cyc.pop_front());
				void'(exp_name.pop_front());
			end
		end
	end

	always @(negedge rclk) begin
		if (!rst && mem_rd && !rd_seen) begin
			mem_reads++;
			last_mem_adr = mem_adr;
		end
		// A miss stalls the request side, hits never do
		if (!rst && busy) begin
			busy_seen = 1'b1;
		end
		rd_seen = mem_rd;
	end

	// ========================================
	// Stimulus tasks
	// ========================================

	// Updated at acceptance so that trailing lookups see an earlier miss as filled
	task automatic predict(input sprite_fetch_pkg::spr_num_t spr,
			input sprite_fetch_pkg::addr_t adr);
		int set;
		set = int'({spr, adr[7:4]});
		exp_hit.push_back(ref_vld[set] && (ref_tag[set] == adr[31:4]));
		exp_line.push_back(line_of({adr[31:4], 4'h0}));
		exp_cyc.push_back(chk_lat ? cyc : -1);
		exp_name.push_back(test_name);
		ref_vld[set] = 1'b1;
		ref_tag[set] = adr[31:4];
	endtask

	task automatic wait_not_busy();
		int guard;
		guard = 0;
		while (busy) begin
			guard++;
			if (guard > wait_limit) stop_on_timeout("busy release");
			@(negedge rclk);
		end
	endtask

	// Holds req high and leaves it high so the next call runs back to back
	task automatic send_req(input sprite_fetch_pkg::spr_num_t spr,
			input sprite_fetch_pkg::addr_t adr);
		int guard;
		guard = 0;
		@(posedge rclk);
		req     <= 1'b1;
		req_spr <= spr;
		req_adr <= adr;
		@(negedge rclk);
		while (busy) begin
			guard++;
			if (guard > 100) stop_on_timeout("request acceptance");
			@(posedge rclk);
			req <= 1'b0;
			@(negedge rclk);
			wait_not_busy();
			@(posedge rclk);
			req <= 1'b1;
			@(negedge rclk);
		end
		predict(spr, adr);
	endtask

	task automatic release_req();
		@(posedge rclk);
		req <= 1'b0;
	endtask

	task automatic wait_drain();
		int guard;
		guard = 0;
		@(negedge rclk);
		while (exp_line.size() != 0 || busy || mem_rd) begin
			guard++;
			if (guard > wait_limit) stop_on_timeout("last response");
			@(negedge rclk);
		end
		repeat (3) @(negedge rclk);
	endtask

	task automatic send_one(input sprite_fetch_pkg::spr_num_t spr,
			input sprite_fetch_pkg::addr_t adr);
		send_req(spr, adr);
		release_req();
		wait_drain();
	endtask

	task automatic invalidate(input sprite_fetch_pkg::spr_num_t spr,
			input sprite_fetch_pkg::addr_t adr);
		@(posedge rclk);
		inv     <= 1'b1;
		inv_spr <= spr;
		inv_adr <= adr;
		@(posedge rclk);
		inv <= 1'b0;
		ref_vld[int'({spr, adr[7:4]})] = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
		tests++;
	endtask

	task automatic finish_test();
		$display("test %s: %0d errors", test_name, errors - test_err0);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		int reads0;
		sprite_fetch_pkg::addr_t a;
		sprite_fetch_pkg::spr_num_t s;
		rclk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		req_spr = '0;
		req_adr = '0;
		inv = 1'b0;
		inv_spr = '0;
		inv_adr = '0;
		cyc = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		chk_lat = 1'b0;
		mem_reads = 0;
		rd_seen = 1'b0;
		busy_seen = 1'b0;
		lfsr_state = 32'h52bc79f9;
		for (int i = 0; i < 512; i++) begin
			ref_vld[i] = 1'b0;
			ref_tag[i] = '0;
		end
		sprs[0] = 5'd3;
		sprs[1] = 5'd7;
		sprs[2] = 5'd12;
		sprs[3] = 5'd30;
		for (int i = 0; i < 4; i++) adrs[i] = rand_bits(32);
		repeat (8) @(posedge rclk);
		rst <= 1'b0;

		start_test("cold_miss");
		for (int i = 0; i < 4; i++) begin
			reads0 = mem_reads;
			busy_seen = 1'b0;
			send_one(sprs[i], adrs[i]);
			check_count("cold_miss reads", reads0 + 1, mem_reads);
			check_adr("cold_miss", {adrs[i][31:4], 4'h0}, last_mem_adr);
			check_busy("cold_miss", 1'b1, busy_seen);
		end
		finish_test();

		start_test("repeat_hit");
		chk_lat = 1'b1;
		reads0 = mem_reads;
		busy_seen = 1'b0;
		for (int i = 0; i < 4; i++) send_one(sprs[i], adrs[i]);
		chk_lat = 1'b0;
		check_count("repeat_hit reads", reads0, mem_reads);
		check_busy("repeat_hit", 1'b0, busy_seen);
		finish_test();

		// Bit 16 lies in the tag, so the set stays the same
		start_test("conflict");
		send_one(sprs[0], adrs[0] ^ 32'h0001_0000);
		send_one(sprs[0], adrs[0]);
		send_one(5'd4, adrs[0]);
		send_one(sprs[0], adrs[0]);
		send_one(5'd4, adrs[0]);
		finish_test();

		start_test("invalidate");
		invalidate(sprs[1], adrs[1]);
		send_one(sprs[1], adrs[1]);
		send_one(sprs[2], adrs[2]);
		send_one(sprs[1], adrs[1]);
		finish_test();

		// Eight sets with two tags each mix hits, misses and conflicts
		start_test("burst");
		for (int i = 0; i < 32; i++) begin
			a = rand_bits(1) ? 32'h0000_1000 : 32'h0000_2000;
			a = a | (rand_bits(2) << 4);
			a = a | rand_bits(4);
			s = sprite_fetch_pkg::spr_num_t'(rand_bits(1));
			send_req(s, a);
		end
		release_req();
		wait_drain();
		finish_test();

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Bound on the whole run
	initial begin
		repeat (200000) @(posedge rclk);
		stop_on_timeout("end of the test sequence");
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/sprite_fetch_pkg.sv
src/sprite_req_stage.sv
src/sprite_read_cache.sv
src/sprite_miss_fetch.sv
src/sprite_fetch_top.sv
testbench/sprite_mem_model.sv
testbench/sprite_fetch_tb.sv
